// ==== design/icache_macros.svh ====
// cache geometry macros. Line words and line count must be powers of two and there must be two lines or more.
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// 32-bit words per line
// also sets the burst beat count and arlen
`define ICACHE_LINE_WORDS 4

// lines in the direct-mapped array
// sets the index width
`define ICACHE_NUM_LINES 4

// byte address width
// the fetch side and the read address channel share it
`define ICACHE_ADDR_W 32

`endif

// ==== design/icache_pkg.sv ====
// cache-side widths follow the geometry macros. The byte offset is always two bits for 32-bit words.
`include "icache_macros.svh"

package icache_pkg;

  // field widths of a fetch address
  localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int INDEX_W = $clog2(`ICACHE_NUM_LINES);
  localparam int TAG_W = `ICACHE_ADDR_W - 2 - OFFSET_W - INDEX_W;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  // one bit wider so a full line count fits
  typedef logic [OFFSET_W:0] beat_t;

  // lookup and refill sequence
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_request,
    st_fill,
    st_respond
  } fetch_state_t;

endpackage

// ==== design/axi_read_pkg.sv ====
// read address channel field types. Only 4-byte incrementing bursts are ever issued.
package axi_read_pkg;

  // arlen carries beats minus one
  typedef logic [7:0] axi_len_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;

  // bytes per beat as a power of two
  localparam axi_size_t AXI_SIZE_4B = 3'b010;

  // incrementing burst kind
  localparam axi_burst_t AXI_BURST_INCR = 2'b01;

  // fixed and wrap kinds are not used here
  // wrap would be 2'b10

endpackage

// ==== design/icache_tag_store.sv ====
// valid and tag array with a combinational hit. Validate and flush must never coincide.
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tag_store
  import icache_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  index_t lookup_index,
  input  tag_t   lookup_tag,
  input  logic   validate,
  input  logic   flush,
  output logic   hit
);

  // one valid bit per line
  logic [`ICACHE_NUM_LINES-1:0] valid;

  // stored tags carry no reset
  // a tag only matters once its valid bit is set
  tag_t tags [`ICACHE_NUM_LINES];

  // hit needs both the valid bit and a tag match
  assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

  // valid bits
  // cleared by reset or fence.i, set when a refill completes
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (flush) begin
      valid <= '0;
    end else if (validate) begin
      valid[lookup_index] <= 1'b1;
    end
  end

  // tag written together with the valid bit
  always_ff @(posedge clock) begin
    if (validate) begin
      tags[lookup_index] <= lookup_tag;
    end
  end

  // controller only validates in respond and only flushes in idle
  // so the two strobes never overlap
  assert property (@(posedge clock) disable iff (reset)
    !(validate && flush))
    else $error("validate and flush raised together");

endmodule

// ==== design/icache_data_store.sv ====
// instruction word array without reset. A line reads correctly only after its refill has completed.
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_data_store
  import icache_pkg::*;
(
  input  logic    clock,
  input  logic    fill_we,
  input  index_t  fill_index,
  input  offset_t fill_offset,
  input  word_t   fill_word,
  input  index_t  read_index,
  input  offset_t read_offset,
  output word_t   inst
);

  // num_lines by line_words words
  word_t mem [`ICACHE_NUM_LINES][`ICACHE_LINE_WORDS];

  // one beat per cycle during a refill
  // offset comes from the beat counter
  always_ff @(posedge clock) begin
    if (fill_we) begin
      mem[fill_index][fill_offset] <= fill_word;
    end
  end

  // asynchronous read at the held fetch address
  // stable while inst_valid is high
  assign inst = mem[read_index][read_offset];

endmodule

// ==== design/icache_controller.sv ====
// single outstanding fetch. The next require waits for inst_valid and fence.i is only legal while idle.
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_controller
  import icache_pkg::*, axi_read_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       require,
  input  addr_t      pc,
  input  logic       fencei,
  input  logic       ctrl_valid,
  input  logic       arready,
  input  logic       rvalid,
  input  word_t      rdata,
  input  logic       rlast,
  input  logic       hit,
  output logic       inst_valid,
  output logic       arvalid,
  output addr_t      araddr,
  output axi_len_t   arlen,
  output axi_size_t  arsize,
  output axi_burst_t arburst,
  output logic       rready,
  output index_t     lookup_index,
  output tag_t       lookup_tag,
  output logic       validate,
  output logic       flush,
  output logic       fill_we,
  output index_t     fill_index,
  output offset_t    fill_offset,
  output word_t      fill_word,
  output index_t     read_index,
  output offset_t    read_offset
);

  // count value of the final beat of a line
  localparam beat_t LAST_BEAT = beat_t'(`ICACHE_LINE_WORDS - 1);

  fetch_state_t state;
  addr_t        pc_q;
  logic         req_q;
  logic         rvalid_q;
  word_t        rdata_q;
  beat_t        beat_cnt;
  logic         last_beat;
  tag_t         pc_tag;
  index_t       pc_index;
  offset_t      pc_offset;

  // held fetch address split into fields
  assign pc_tag = pc_q[`ICACHE_ADDR_W-1 -: TAG_W];
  assign pc_index = pc_q[OFFSET_W+2 +: INDEX_W];
  assign pc_offset = pc_q[2 +: OFFSET_W];

  // pc captured on the request pulse
  always_ff @(posedge clock) begin
    if (require) begin
      pc_q <= pc;
    end
  end

  // request delayed one cycle
  // lookup starts the cycle after pc is held
  always_ff @(posedge clock) begin
    if (reset) begin
      req_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      req_q <= require;
      rvalid_q <= rvalid;
    end
  end

  // bus beat staged once before the array write
  always_ff @(posedge clock) begin
    if (rvalid) begin
      rdata_q <= rdata;
    end
  end

  // staged beat goes into the array only during fill
  assign fill_we = rvalid_q && (state == st_fill);
  assign last_beat = fill_we && (beat_cnt == LAST_BEAT);

  // lookup and refill sequence
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      arvalid <= 1'b0;
      inst_valid <= 1'b0;
      beat_cnt <= '0;
    end else begin
      // inst_valid is a one-cycle pulse
      inst_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (req_q) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (hit) begin
            inst_valid <= 1'b1;
            state <= st_idle;
          end else begin
            // miss starts a line burst
            arvalid <= 1'b1;
            state <= st_request;
          end
        end
        st_request: begin
          // arvalid holds until the slave accepts
          if (arready) begin
            arvalid <= 1'b0;
            state <= st_fill;
          end
        end
        st_fill: begin
          // rvalid gaps simply stall the count
          if (fill_we) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= st_respond;
            end
          end
        end
        st_respond: begin
          inst_valid <= 1'b1;
          beat_cnt <= '0;
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // tag written and valid set during respond
  assign validate = (state == st_respond);
  assign flush = fencei && ctrl_valid && (state == st_idle);

  // store addresses all follow the held pc
  assign lookup_index = pc_index;
  assign lookup_tag = pc_tag;
  assign fill_index = pc_index;
  assign fill_offset = offset_t'(beat_cnt);
  assign fill_word = rdata_q;
  assign read_index = pc_index;
  assign read_offset = pc_offset;

  // line-aligned burst of fixed shape
  assign araddr = {pc_tag, pc_index, {(OFFSET_W + 2){1'b0}}};
  assign arlen = axi_len_t'(`ICACHE_LINE_WORDS - 1);
  assign arsize = AXI_SIZE_4B;
  assign arburst = AXI_BURST_INCR;
  assign rready = 1'b1;

  // bus rlast must land on the beat the counter takes as final
  assert property (@(posedge clock) disable iff (reset)
    rvalid_q |-> ($past(rlast) == (beat_cnt == LAST_BEAT)))
    else $error("rlast does not match the counted final beat");

  // pending request keeps both arvalid and its address
  // a new require during a refill would move araddr
  assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");

  // fence.i issued while a fetch is in progress
  assert property (@(posedge clock) disable iff (reset)
    fencei && ctrl_valid |-> state == st_idle)
    else $error("fence.i outside idle");

endmodule

// ==== design/icache_top.sv ====
// instruction cache top with AXI-style read channels only. rready stays high so the slave is never stalled.
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*, axi_read_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  // fetch side
  input  logic       require,
  input  addr_t      pc,
  input  logic       fencei,
  input  logic       ctrl_valid,
  output logic       inst_valid,
  output word_t      inst,
  // read address channel
  output logic       arvalid,
  input  logic       arready,
  output addr_t      araddr,
  output axi_len_t   arlen,
  output axi_size_t  arsize,
  output axi_burst_t arburst,
  // read data channel
  input  logic       rvalid,
  output logic       rready,
  input  word_t      rdata,
  input  logic       rlast
);

  logic    hit;
  logic    validate;
  logic    flush;
  logic    fill_we;
  index_t  lookup_index;
  tag_t    lookup_tag;
  index_t  fill_index;
  offset_t fill_offset;
  word_t   fill_word;
  index_t  read_index;
  offset_t read_offset;

  // sequencing and bus side
  icache_controller icache_controller_inst (
    .clock        (clock),
    .reset        (reset),
    .require      (require),
    .pc           (pc),
    .fencei       (fencei),
    .ctrl_valid   (ctrl_valid),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rlast        (rlast),
    .hit          (hit),
    .inst_valid   (inst_valid),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arsize       (arsize),
    .arburst      (arburst),
    .rready       (rready),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .validate     (validate),
    .flush        (flush),
    .fill_we      (fill_we),
    .fill_index   (fill_index),
    .fill_offset  (fill_offset),
    .fill_word    (fill_word),
    .read_index   (read_index),
    .read_offset  (read_offset)
  );

  // valid bits and tags
  icache_tag_store icache_tag_store_inst (
    .clock        (clock),
    .reset        (reset),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .validate     (validate),
    .flush        (flush),
    .hit          (hit)
  );

  // instruction words
  // the read port drives inst directly
  icache_data_store icache_data_store_inst (
    .clock       (clock),
    .fill_we     (fill_we),
    .fill_index  (fill_index),
    .fill_offset (fill_offset),
    .fill_word   (fill_word),
    .read_index  (read_index),
    .read_offset (read_offset),
    .inst        (inst)
  );

endmodule

// ==== sim/burst_memory_model.sv ====
// read slave for simulation only. One burst at a time, no error responses, words derived from the address.
`timescale 1ns/1ps

module burst_memory_model
  import icache_pkg::*, axi_read_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     arvalid,
  output logic     arready,
  input  addr_t    araddr,
  input  axi_len_t arlen,
  output logic     rvalid,
  input  logic     rready,
  output word_t    rdata,
  output logic     rlast,
  output int       burst_count
);

  // content rule of the whole address space
  localparam word_t DATA_MASK = 32'hc001_d00d;

  logic [31:0] lfsr = 32'h21bf_89df;
  int          phase;
  int          wait_cnt;
  int          gap;
  int          beat;
  addr_t       base;
  axi_len_t    len;

  // fibonacci taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output int value);
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  initial begin
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rlast = 1'b0;
    burst_count = 0;
    phase = 0;
  end

  // outputs change on the falling edge only
  always @(negedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      rlast <= 1'b0;
      phase = 0;
      beat = 0;
    end else begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      rlast <= 1'b0;
      case (phase)
        // request seen, pick 0 to 3 extra wait cycles
        0: begin
          if (arvalid) begin
            draw_bits(2, wait_cnt);
            phase = 1;
          end
        end
        // accept once the delay ran out
        1: begin
          if (wait_cnt == 0) begin
            arready <= 1'b1;
            base = araddr;
            len = arlen;
            beat = 0;
            burst_count++;
            phase = 2;
          end else begin
            wait_cnt--;
          end
        end
        // beats with random single-cycle gaps
        default: begin
          draw_bits(1, gap);
          if (gap == 0 && rready) begin
            rvalid <= 1'b1;
            rdata <= (base + addr_t'(beat * 4)) ^ DATA_MASK;
            rlast <= (beat == int'(len));
            if (beat == int'(len)) begin
              phase = 0;
            end else begin
              beat++;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== sim/icache_tb.sv ====
// cache testbench. Run from the project root so that sim/icache_stimulus.txt is found; default geometry assumed.
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb
  import icache_pkg::*, axi_read_pkg::*;
();

  localparam string STIM_PATH = "sim/icache_stimulus.txt";
  localparam word_t DATA_MASK = 32'hc001_d00d;
  localparam int LINE_BYTES = `ICACHE_LINE_WORDS * 4;
  localparam int HIT_LATENCY = 2;
  localparam int CYCLES_PER_OP = 200;

  logic       clock;
  logic       reset;
  logic       require;
  addr_t      pc;
  logic       fencei;
  logic       ctrl_valid;
  logic       inst_valid;
  word_t      inst;
  logic       arvalid;
  logic       arready;
  addr_t      araddr;
  axi_len_t   arlen;
  axi_size_t  arsize;
  axi_burst_t arburst;
  logic       rvalid;
  logic       rready;
  word_t      rdata;
  logic       rlast;
  int         burst_count;
  int         error_count = 0;
  int         check_count = 0;
  int         fetch_count = 0;
  int         limit_cycles = 0;

  icache_top icache_top_inst (
    .clock(clock), .reset(reset), .require(require), .pc(pc),
    .fencei(fencei), .ctrl_valid(ctrl_valid), .inst_valid(inst_valid), .inst(inst),
    .arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
    .arsize(arsize), .arburst(arburst), .rvalid(rvalid), .rready(rready),
    .rdata(rdata), .rlast(rlast)
  );

  // bus slave with random accept delay and beat gaps
  burst_memory_model memory_inst (
    .clock(clock), .reset(reset), .arvalid(arvalid), .arready(arready),
    .araddr(araddr), .arlen(arlen), .rvalid(rvalid), .rready(rready),
    .rdata(rdata), .rlast(rlast), .burst_count(burst_count)
  );

  // 20 ns period
  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  // one fetch, waits for inst_valid under the watchdog
  task automatic run_fetch(input addr_t fetch_pc, input int expect_miss);
    int    cycles;
    int    bursts_before;
    logic  request_seen;
    bursts_before = burst_count;
    request_seen = 1'b0;
    require = 1'b1;
    pc = fetch_pc;
    @(negedge clock);
    require = 1'b0;
    cycles = 1;
    while (!inst_valid) begin
      // burst shape checked on the first cycle arvalid shows
      if (arvalid && !request_seen) begin
        request_seen = 1'b1;
        check_value("araddr", araddr, fetch_pc & ~addr_t'(LINE_BYTES - 1));
        check_value("arlen", 32'(arlen), `ICACHE_LINE_WORDS - 1);
        check_value("arsize", 32'(arsize), 32'b010);
        check_value("arburst", 32'(arburst), 32'b01);
        check_value("rready", rready, 1'b1);
      end
      @(negedge clock);
      cycles++;
    end
    check_value("inst", inst, fetch_pc ^ DATA_MASK);
    check_value("burst count", burst_count - bursts_before, expect_miss);
    // edges after the sampling edge of require
    if (expect_miss == 0) begin
      check_value("hit latency", cycles - 1, HIT_LATENCY);
    end
    @(negedge clock);
    check_value("inst_valid", inst_valid, 1'b0);
    fetch_count++;
  endtask

  // ctrl_valid pulse, fencei as given
  task automatic run_fence(input int with_fencei);
    fencei = (with_fencei != 0);
    ctrl_valid = 1'b1;
    @(negedge clock);
    fencei = 1'b0;
    ctrl_valid = 1'b0;
    @(negedge clock);
  endtask

  task automatic count_operations(output int n);
    int               fd;
    int               code;
    logic [8*8-1:0]   op;
    logic [8*128-1:0] skip_line;
    n = -1;
    fd = $fopen(STIM_PATH, "r");
    if (fd != 0) begin
      n = 0;
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", op);
        if (code == 1) begin
          if (op == "fetch" || op == "fence") begin
            n++;
          end
          code = $fgets(skip_line, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic print_summary();
    $display("summary: %0d checks, %0d errors, %0d fetches, %0d bursts",
             check_count, error_count, fetch_count, burst_count);
  endtask

  initial begin : main_sequence
    int               fd;
    int               code;
    int               ops;
    int               miss_flag;
    int               fence_bit;
    addr_t            fetch_pc;
    logic [8*8-1:0]   op;
    logic [8*128-1:0] skip_line;
    clock = 1'b0;
    reset = 1'b1;
    require = 1'b0;
    pc = '0;
    fencei = 1'b0;
    ctrl_valid = 1'b0;
    count_operations(ops);
    if (ops < 0) begin
      $display("could not open stimulus file %s", STIM_PATH);
      error_count++;
    end else begin
      // reset and a margin counted as extra operations
      limit_cycles = (ops + 2) * CYCLES_PER_OP;
      repeat (5) begin
        @(negedge clock);
        check_value("arvalid", arvalid, 1'b0);
        check_value("inst_valid", inst_valid, 1'b0);
      end
      reset = 1'b0;
      @(negedge clock);
      check_value("arvalid", arvalid, 1'b0);
      check_value("inst_valid", inst_valid, 1'b0);
      fd = $fopen(STIM_PATH, "r");
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", op);
        if (code == 1) begin
          if (op == "#") begin
            code = $fgets(skip_line, fd);
          end else if (op == "fetch") begin
            code = $fscanf(fd, "%h %d", fetch_pc, miss_flag);
            run_fetch(fetch_pc, miss_flag);
          end else if (op == "fence") begin
            code = $fscanf(fd, "%d", fence_bit);
            run_fence(fence_bit);
          end else begin
            $display("unknown operation in stimulus file at %0t ns", $time);
            error_count++;
            code = $fgets(skip_line, fd);
          end
        end
      end
      $fclose(fd);
    end
    print_summary();
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // run length bound from the operation count
  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles, a fetch never completed", limit_cycles);
    error_count++;
    print_summary();
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+design
design/icache_pkg.sv
design/axi_read_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_controller.sv
design/icache_top.sv
sim/burst_memory_model.sv
sim/icache_tb.sv

// ==== sim/icache_stimulus.txt ====
# fetch <pc in hex> <expected miss flag, 1 for a refill burst>
# fence <fencei bit, ctrl_valid is raised in both cases>
fetch 00001000 1
fetch 00001004 0
fetch 0000100c 0
fetch 00001008 0
fetch 00001014 1
fetch 00001010 0
fetch 00002000 1
fetch 00001000 1
fetch 00002004 1
fetch 00001008 1
fence 0
fetch 0000100c 0
fetch 00001018 0
fence 1
fetch 00001004 1
fetch 00001010 1
fetch 8000003c 1
fetch 80000030 0
